// ==== files.f ====
+incdir+src
src/rv_wb_pkg.sv
src/mem_wb_if.sv
src/mem_access_stage.sv
src/mem_wb_regs.sv
src/wb_stage.sv
src/mem_wb_top.sv
verif/mem_wb_assert.sv
verif/mem_wb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the MEM/WB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module mem_wb_tb -Mdir obj_dir -o mem_wb_sim

./obj_dir/mem_wb_sim 2>&1 | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// ==== src/mem_access_stage.sv ====
`timescale 1ns/100ps
`include "rv_wb_config.svh"

module mem_access_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  hold_i,
	input  logic                  in_valid_i,
	input  logic                  in_reg_wen_i,
	input  logic [`RV_REG_AW-1:0] in_reg_waddr_i,
	input  logic [`RV_XLEN-1:0]   in_alu_res_i,
	input  logic [`RV_XLEN-1:0]   in_store_data_i,
	input  rv_wb_pkg::mem_op_t    in_op_i,
	input  logic                  in_ebreak_i,
	input  logic [`RV_XLEN-1:0]   in_pc_i,
	mem_wb_if.src                 out
);
	import rv_wb_pkg::*;

	localparam int DMEM_AW = $clog2(`RV_DMEM_DEPTH);

	logic [`RV_XLEN-1:0] dmem [0:`RV_DMEM_DEPTH-1];
	logic [DMEM_AW-1:0]  dmem_idx;
	logic [2:0]          byte_off;   // first byte of the lane
	logic [7:0]          size_mask;
	logic [7:0]          wmask;
	logic [`RV_XLEN-1:0] wdata;
	logic                take;

	assign take     = in_valid_i & ~hold_i;
	assign dmem_idx = in_alu_res_i[3 +: DMEM_AW]; // doubleword index, wraps

	// misaligned accesses fall back to the aligned lane
	always_comb begin
		unique case (in_op_i.size)
			SZ_BYTE: begin
				size_mask = 8'h01;
				byte_off  = in_alu_res_i[2:0];
			end
			SZ_HALF: begin
				size_mask = 8'h03;
				byte_off  = {in_alu_res_i[2:1], 1'b0};
			end
			SZ_WORD: begin
				size_mask = 8'h0f;
				byte_off  = {in_alu_res_i[2], 2'b00};
			end
			default: begin
				size_mask = 8'hff;
				byte_off  = 3'd0;
			end
		endcase
	end

	assign wmask = size_mask << byte_off;
	assign wdata = in_store_data_i << {byte_off, 3'b000}; // move store data onto its lane

	// data memory: masked write and registered read, both at the sampling edge
	always_ff @(posedge clk) begin
		if (take && in_op_i.store) begin
			for (int i = 0; i < 8; i++) begin
				if (wmask[i])
					dmem[dmem_idx][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
		if (take && in_op_i.load)
			out.rdata <= dmem[dmem_idx];
	end

	// stage register, frozen by hold
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out.valid     <= 1'b0;
			out.reg_wen   <= 1'b0;
			out.reg_waddr <= '0;
			out.alu_res   <= '0;
			out.op        <= '0;
			out.ebreak    <= 1'b0;
			out.pc        <= `RV_RESET_PC;
		end else if (!hold_i) begin
			out.valid     <= in_valid_i; // bubble when nothing is offered
			out.reg_wen   <= in_reg_wen_i;
			out.reg_waddr <= in_reg_waddr_i;
			out.alu_res   <= in_alu_res_i;
			out.op        <= in_op_i;
			out.ebreak    <= in_ebreak_i;
			out.pc        <= in_pc_i;
		end
	end

endmodule

// ==== src/mem_wb_if.sv ====
`timescale 1ns/100ps
`include "rv_wb_config.svh"

interface mem_wb_if;
	import rv_wb_pkg::*;

	logic                  valid;
	logic                  reg_wen;
	logic [`RV_REG_AW-1:0] reg_waddr;
	logic [`RV_XLEN-1:0]   alu_res;   // also the memory address
	ld_data_u              rdata;     // synchronous read result
	mem_op_t               op;
	logic                  ebreak;
	logic [`RV_XLEN-1:0]   pc;

	// sending stage
	modport src (
		output valid,
		output reg_wen,
		output reg_waddr,
		output alu_res,
		output rdata,
		output op,
		output ebreak,
		output pc
	);

	// receiving stage
	modport dst (
		input valid,
		input reg_wen,
		input reg_waddr,
		input alu_res,
		input rdata,
		input op,
		input ebreak,
		input pc
	);

endinterface

// ==== src/mem_wb_regs.sv ====
`timescale 1ns/100ps
`include "rv_wb_config.svh"

module mem_wb_regs (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   hold_i,
	input  logic   flush_i,
	mem_wb_if.dst  in,
	mem_wb_if.src  out
);

	logic load_en;

	assign load_en = ~hold_i;

	// valid bit: flush wins over hold
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out.valid <= 1'b0;
		else if (flush_i)
			out.valid <= 1'b0;
		else if (load_en)
			out.valid <= in.valid;
	end

	// payload of the bundle
	// a flushed slot keeps whatever it loaded, only valid drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out.reg_wen   <= 1'b0;
			out.reg_waddr <= '0;
			out.alu_res   <= '0;
			out.rdata     <= '0;
			out.op        <= '0;
			out.ebreak    <= 1'b0;
			out.pc        <= `RV_RESET_PC;
		end else if (load_en) begin
			out.reg_wen   <= in.reg_wen;
			out.reg_waddr <= in.reg_waddr;
			out.alu_res   <= in.alu_res;
			out.rdata     <= in.rdata;
			out.op        <= in.op;
			out.ebreak    <= in.ebreak;
			out.pc        <= in.pc;
		end
	end

endmodule

// ==== src/mem_wb_top.sv ====
`timescale 1ns/100ps
`include "rv_wb_config.svh"

module mem_wb_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  hold_i,
	input  logic                  flush_i,
	input  logic                  in_valid_i,
	input  logic                  in_reg_wen_i,
	input  logic [`RV_REG_AW-1:0] in_reg_waddr_i,
	input  logic [`RV_XLEN-1:0]   in_alu_res_i,
	input  logic [`RV_XLEN-1:0]   in_store_data_i,
	input  rv_wb_pkg::mem_op_t    in_op_i,
	input  logic                  in_ebreak_i,
	input  logic [`RV_XLEN-1:0]   in_pc_i,
	input  logic [`RV_REG_AW-1:0] dbg_raddr_i,
	output logic                  retire_valid_o,
	output logic [`RV_REG_AW-1:0] retire_rd_o,
	output logic [`RV_XLEN-1:0]   retire_data_o,
	output logic [`RV_XLEN-1:0]   retire_pc_o,
	output logic                  halt_o,
	output logic [`RV_XLEN-1:0]   dbg_rdata_o
);

	mem_wb_if mem_bus (); // mem stage -> MEM/WB register
	mem_wb_if wb_bus ();  // MEM/WB register -> write-back

	mem_access_stage u_mem (
		.clk             (clk),
		.rst_n           (rst_n),
		.hold_i          (hold_i),
		.in_valid_i      (in_valid_i),
		.in_reg_wen_i    (in_reg_wen_i),
		.in_reg_waddr_i  (in_reg_waddr_i),
		.in_alu_res_i    (in_alu_res_i),
		.in_store_data_i (in_store_data_i),
		.in_op_i         (in_op_i),
		.in_ebreak_i     (in_ebreak_i),
		.in_pc_i         (in_pc_i),
		.out             (mem_bus.src)
	);

	mem_wb_regs u_mem_wb (
		.clk     (clk),
		.rst_n   (rst_n),
		.hold_i  (hold_i),
		.flush_i (flush_i),
		.in      (mem_bus.dst),
		.out     (wb_bus.src)
	);

	wb_stage u_wb (
		.clk            (clk),
		.rst_n          (rst_n),
		.hold_i         (hold_i),
		.dbg_raddr_i    (dbg_raddr_i),
		.in             (wb_bus.dst),
		.retire_valid_o (retire_valid_o),
		.retire_rd_o    (retire_rd_o),
		.retire_data_o  (retire_data_o),
		.retire_pc_o    (retire_pc_o),
		.halt_o         (halt_o),
		.dbg_rdata_o    (dbg_rdata_o)
	);

endmodule

// ==== src/rv_wb_config.svh ====
`ifndef RV_WB_CONFIG_SVH
`define RV_WB_CONFIG_SVH

// machine word, also the width of pc and load data
`define RV_XLEN 64

// x0..x31
`define RV_REG_AW 5

// data memory in doublewords
// index is addr >> 3, wraps at the depth
`define RV_DMEM_DEPTH 512

// pc value held in the stage registers after reset
`define RV_RESET_PC 64'h8000_0000

`endif

// ==== src/rv_wb_pkg.sv ====
`include "rv_wb_config.svh"

package rv_wb_pkg;

	// access size of a load or store
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'b00,
		SZ_HALF  = 2'b01,
		SZ_WORD  = 2'b10,
		SZ_DWORD = 2'b11
	} ld_size_e;

	// memory control that travels with the instruction
	typedef struct packed {
		logic     load;  // read dmem, write back the extended lane
		logic     store; // write dmem under the byte mask
		ld_size_e size;
		logic     unsgn; // zero extend instead of sign extend
	} mem_op_t;

	// one read doubleword, seen lane by lane
	// wb indexes the view that matches the size with addr[2:0]
	typedef union packed {
		logic [`RV_XLEN/8-1:0][7:0]   b;
		logic [`RV_XLEN/16-1:0][15:0] h;
		logic [`RV_XLEN/32-1:0][31:0] w;
		logic [`RV_XLEN-1:0]          d;
	} ld_data_u;

endpackage

// ==== src/wb_stage.sv ====
`timescale 1ns/100ps
`include "rv_wb_config.svh"

module wb_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  hold_i,
	input  logic [`RV_REG_AW-1:0] dbg_raddr_i,
	mem_wb_if.dst                 in,
	output logic                  retire_valid_o,
	output logic [`RV_REG_AW-1:0] retire_rd_o,
	output logic [`RV_XLEN-1:0]   retire_data_o,
	output logic [`RV_XLEN-1:0]   retire_pc_o,
	output logic                  halt_o,
	output logic [`RV_XLEN-1:0]   dbg_rdata_o
);
	import rv_wb_pkg::*;

	localparam int NREGS = 1 << `RV_REG_AW;

	logic [`RV_XLEN-1:0] rf [0:NREGS-1]; // entry 0 never written
	logic [2:0]          off;
	logic [7:0]          lane_b;
	logic [15:0]         lane_h;
	logic [31:0]         lane_w;
	logic                sx;             // sign extension wanted
	logic [`RV_XLEN-1:0] load_val;
	logic [`RV_XLEN-1:0] wb_data;
	logic                rf_we;
	logic                halt_q;

	// lane pick, same aligned rule as the store mask
	assign off    = in.alu_res[2:0];
	assign lane_b = in.rdata.b[off];
	assign lane_h = in.rdata.h[off[2:1]];
	assign lane_w = in.rdata.w[off[2]];
	assign sx     = ~in.op.unsgn;

	always_comb begin
		unique case (in.op.size)
			SZ_BYTE:  load_val = {{(`RV_XLEN-8){sx & lane_b[7]}}, lane_b};
			SZ_HALF:  load_val = {{(`RV_XLEN-16){sx & lane_h[15]}}, lane_h};
			SZ_WORD:  load_val = {{(`RV_XLEN-32){sx & lane_w[31]}}, lane_w};
			default:  load_val = in.rdata.d;
		endcase
	end

	assign wb_data = in.op.load ? load_val : in.alu_res; // alu ops pass straight through

	// retire report, silent while held
	assign retire_valid_o = in.valid & ~hold_i;
	assign retire_rd_o    = in.reg_waddr;
	assign retire_data_o  = wb_data;
	assign retire_pc_o    = in.pc;

	// register file, x0 stays zero
	assign rf_we = retire_valid_o & in.reg_wen & (in.reg_waddr != '0);

	always_ff @(posedge clk) begin
		if (rf_we)
			rf[in.reg_waddr] <= wb_data;
	end

	assign dbg_rdata_o = (dbg_raddr_i == '0) ? '0 : rf[dbg_raddr_i];

	// sticky halt once an ebreak retires
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			halt_q <= 1'b0;
		else if (retire_valid_o && in.ebreak)
			halt_q <= 1'b1;
	end

	// high already in the retiring cycle
	assign halt_o = halt_q | (retire_valid_o & in.ebreak);

endmodule

// ==== verif/mem_wb_assert.sv ====
`timescale 1ns/100ps
`include "rv_wb_config.svh"

module mem_wb_assert (
	input logic                                   clk,
	input logic                                   rst_n,
	input logic                                   hold_i,
	input logic                                   flush_i,
	input logic                                   valid,
	input logic [`RV_XLEN-1:0]                    pc,
	input logic [`RV_REG_AW+2*`RV_XLEN+6:0]       payload // every field but valid and pc
);

	// a held register keeps everything unless flush drops valid
	property p_hold_stable;
		@(posedge clk) disable iff (!rst_n)
		hold_i && !flush_i |=> $stable(valid) && $stable(pc) && $stable(payload);
	endproperty

	a_hold_stable: assert property (p_hold_stable)
		else $error("MEM/WB register changed while held");

	a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n) flush_i |=> !valid)
		else $error("MEM/WB valid still set after flush");

	a_reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> pc == `RV_RESET_PC)
		else $error("MEM/WB pc not at reset value after reset");

endmodule

bind mem_wb_regs mem_wb_assert u_regs_assert (
	.clk     (clk),
	.rst_n   (rst_n),
	.hold_i  (hold_i),
	.flush_i (flush_i),
	.valid   (out.valid),
	.pc      (out.pc),
	.payload ({out.reg_wen, out.reg_waddr, out.alu_res, out.rdata, out.op, out.ebreak})
);

// ==== verif/mem_wb_tb.sv ====
`timescale 1ns/100ps
`include "rv_wb_config.svh"

module mem_wb_tb;
	import rv_wb_pkg::*;

	typedef struct {
		mem_op_t               op;
		logic [`RV_XLEN-1:0]   addr;    // alu result and memory address
		logic [`RV_XLEN-1:0]   sdata;
		logic [`RV_REG_AW-1:0] rd;
		logic                  wen;
		logic                  ebreak;
		int                    hold;    // hold cycles right after issue
		logic                  flush;   // flush pulse the cycle after issue
		logic [`RV_XLEN-1:0]   exp_val; // expected retire data
	} row_t;

	typedef struct packed {
		logic [`RV_REG_AW-1:0] rd;
		logic [`RV_XLEN-1:0]   data;
		logic [`RV_XLEN-1:0]   pc;
		logic                  ebreak;
		logic [31:0]           due;     // pipeline edge count at retirement
	} ret_t;

	logic                  clk;
	logic                  rst_n;
	logic                  hold_i;
	logic                  flush_i;
	logic                  in_valid_i;
	logic                  in_reg_wen_i;
	logic [`RV_REG_AW-1:0] in_reg_waddr_i;
	logic [`RV_XLEN-1:0]   in_alu_res_i;
	logic [`RV_XLEN-1:0]   in_store_data_i;
	mem_op_t               in_op_i;
	logic                  in_ebreak_i;
	logic [`RV_XLEN-1:0]   in_pc_i;
	logic [`RV_REG_AW-1:0] dbg_raddr_i;
	logic                  retire_valid_o;
	logic [`RV_REG_AW-1:0] retire_rd_o;
	logic [`RV_XLEN-1:0]   retire_data_o;
	logic [`RV_XLEN-1:0]   retire_pc_o;
	logic                  halt_o;
	logic [`RV_XLEN-1:0]   dbg_rdata_o;

	row_t                tbl[$];
	ret_t                exp_q[$];  // issued but not yet retired
	logic [`RV_XLEN-1:0] mmem [0:`RV_DMEM_DEPTH-1]; // data memory model
	logic [`RV_XLEN-1:0] mrf [0:31];
	logic [`RV_XLEN-1:0] mid_rf [0:31]; // register model after the directed rows
	logic [`RV_XLEN-1:0] want_rf [0:31];
	logic [31:0]         lcg_state = 32'hd5de_6ca5;
	logic [31:0]         adv_cnt = 32'd0; // edges that move the pipeline
	logic                halt_seen = 1'b0;
	logic                timed_out;
	int                  errors = 0;
	int                  nchecks = 0;
	int                  n_dir;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	mem_wb_top DUT (
		.clk             (clk),
		.rst_n           (rst_n),
		.hold_i          (hold_i),
		.flush_i         (flush_i),
		.in_valid_i      (in_valid_i),
		.in_reg_wen_i    (in_reg_wen_i),
		.in_reg_waddr_i  (in_reg_waddr_i),
		.in_alu_res_i    (in_alu_res_i),
		.in_store_data_i (in_store_data_i),
		.in_op_i         (in_op_i),
		.in_ebreak_i     (in_ebreak_i),
		.in_pc_i         (in_pc_i),
		.dbg_raddr_i     (dbg_raddr_i),
		.retire_valid_o  (retire_valid_o),
		.retire_rd_o     (retire_rd_o),
		.retire_data_o   (retire_data_o),
		.retire_pc_o     (retire_pc_o),
		.halt_o          (halt_o),
		.dbg_rdata_o     (dbg_rdata_o)
	);

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// aligned lane of a doubleword with sign or zero extension
	function automatic logic [63:0] lane_value(input logic [63:0] dw, input ld_size_e sz,
			input logic [2:0] off, input logic uns);
		int          nb;
		int          base;
		logic [63:0] v;
		logic [63:0] m;
		nb   = 1 << int'(sz);
		base = int'(off) / nb * nb;
		v    = dw >> (8 * base);
		if (nb == 8)
			return v;
		m = (64'd1 << (8 * nb)) - 64'd1;
		v = v & m;
		if (!uns && v[8*nb-1])
			v = v | ~m;
		return v;
	endfunction

	task automatic store_model(input int idx, input ld_size_e sz, input logic [2:0] off,
			input logic [63:0] data);
		int nb;
		int base;
		nb   = 1 << int'(sz);
		base = int'(off) / nb * nb;
		for (int b = 0; b < nb; b++)
			mmem[idx][8*(base+b) +: 8] = data[8*b +: 8];
	endtask

	// appends one row and runs the models in issue order
	task automatic add_row(input logic ld, input logic st, input ld_size_e sz, input logic uns,
			input logic [63:0] addr, input logic [63:0] sdata, input logic [4:0] rd,
			input logic wen, input logic ebk, input int hold, input logic flush);
		row_t r;
		int   idx;
		idx       = int'((addr >> 3) % `RV_DMEM_DEPTH);
		r.op      = '{load: ld, store: st, size: sz, unsgn: uns};
		r.addr    = addr;
		r.sdata   = sdata;
		r.rd      = rd;
		r.wen     = wen;
		r.ebreak  = ebk;
		r.hold    = hold;
		r.flush   = flush;
		if (st)
			store_model(idx, sz, addr[2:0], sdata); // memory is written even if flushed later
		r.exp_val = ld ? lane_value(mmem[idx], sz, addr[2:0], uns) : addr;
		if (wen && rd != '0 && !flush)
			mrf[rd] = r.exp_val;
		tbl.push_back(r);
	endtask

	task automatic build_table();
		int          n;
		int          kind;
		logic [31:0] r;
		logic [63:0] v;
		for (int i = 0; i < 32; i++)
			mrf[i] = '0;
		// give every register a value including x0
		for (int i = 0; i < 32; i++)
			add_row(0, 0, SZ_DWORD, 0, {lcg_next(), lcg_next()}, '0, 5'(i), 1, 0, 0, 0);
		for (int i = 0; i < 16; i++) // region for the random loads
			add_row(0, 1, SZ_DWORD, 0, 64'h1000 + 64'(8 * i), {lcg_next(), lcg_next()},
				'0, 0, 0, 0, 0);
		add_row(0, 1, SZ_DWORD, 0, 64'h1100, 64'hf0e1_d2c3_b4a5_9687, '0, 0, 0, 0, 0);
		n = 0;
		for (int off = 0; off < 8; off++) begin
			for (int s = 0; s < 4; s++) begin
				for (int u = 0; u < 2; u++) begin
					add_row(1, 0, ld_size_e'(s), u[0], 64'h1100 + 64'(off), '0,
						5'(1 + n % 31), 1, 0, 0, 0);
					n++;
				end
			end
		end
		add_row(0, 1, SZ_BYTE, 0, 64'h1101, 64'h5a, '0, 0, 0, 0, 0);
		add_row(0, 1, SZ_HALF, 0, 64'h1107, 64'h7e81, '0, 0, 0, 0, 0); // misaligned half in lane 6
		add_row(1, 0, SZ_DWORD, 0, 64'h1100, '0, 5'd20, 1, 0, 0, 0);
		add_row(1, 0, SZ_HALF, 1, 64'h1106, '0, 5'd21, 1, 0, 0, 0);
		add_row(1, 0, SZ_BYTE, 0, 64'h1101, '0, 5'd22, 1, 0, 0, 0);
		add_row(0, 0, SZ_DWORD, 0, 64'h0123_4567_89ab_cdef, '0, 5'd11, 1, 0, 5, 0);
		add_row(1, 0, SZ_WORD, 0, 64'h1104, '0, 5'd12, 1, 0, 3, 0);
		add_row(0, 0, SZ_DWORD, 0, 64'h1111, '0, 5'd13, 1, 0, 0, 0);
		add_row(0, 0, SZ_DWORD, 0, 64'h2222, '0, 5'd13, 1, 0, 0, 1); // flushed
		add_row(0, 0, SZ_DWORD, 0, 64'h3333, '0, 5'd14, 1, 0, 0, 0);
		add_row(1, 0, SZ_DWORD, 0, 64'h1100, '0, 5'd15, 1, 0, 0, 0); // no junk from the holds
		add_row(0, 0, SZ_DWORD, 0, 64'h0, '0, 5'd0, 0, 1, 0, 0);      // ebreak
		n_dir  = tbl.size();
		mid_rf = mrf;
		for (int i = 0; i < 40; i++) begin
			r    = lcg_next();
			v    = {lcg_next(), lcg_next()};
			kind = int'(r[15:8]) % 3;
			if (kind == 0)
				add_row(0, 0, SZ_DWORD, 0, v, '0, r[28:24], 1, 0, 0, 0);
			else if (kind == 1)
				add_row(0, 1, ld_size_e'(r[31:30]), 0, 64'h1000 + 64'(r[22:16]), v,
					r[28:24], 0, 0, 0, 0);
			else
				add_row(1, 0, ld_size_e'(r[31:30]), r[29], 64'h1000 + 64'(r[22:16]), '0,
					r[28:24], 1, 0, 0, 0);
		end
	endtask

	task compare_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		nchecks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic drive_row(input row_t r, input logic [63:0] pc);
		hold_i          = 1'b0;
		flush_i         = 1'b0;
		in_valid_i      = 1'b1;
		in_reg_wen_i    = r.wen;
		in_reg_waddr_i  = r.rd;
		in_alu_res_i    = r.addr;
		in_store_data_i = r.sdata;
		in_op_i         = r.op;
		in_ebreak_i     = r.ebreak;
		in_pc_i         = pc;
	endtask

	task automatic apply_rows(input int first, input int last);
		logic [63:0] pc;
		for (int i = first; i < last; i++) begin
			pc = `RV_RESET_PC + 64'(4 * i);
			@(posedge clk);
			#1;
			drive_row(tbl[i], pc);
			// sampled on the next edge, captured by MEM/WB on the one after
			if (!tbl[i].flush)
				exp_q.push_back('{tbl[i].rd, tbl[i].exp_val, pc, tbl[i].ebreak,
					adv_cnt + 32'd2});
			for (int h = 0; h < tbl[i].hold; h++) begin
				@(posedge clk);
				#1;
				hold_i          = 1'b1;
				in_op_i         = '{load: 1'b0, store: 1'b1, size: SZ_DWORD, unsgn: 1'b0};
				in_alu_res_i    = 64'h1100; // offered store that must be ignored
				in_store_data_i = 64'hbad0_bad0_bad0_bad0;
				in_reg_waddr_i  = 5'd31;
			end
			if (tbl[i].flush) begin
				@(posedge clk);
				#1;
				in_valid_i = 1'b0;
				flush_i    = 1'b1;
			end
		end
		@(posedge clk);
		#1;
		in_valid_i = 1'b0;
		hold_i     = 1'b0;
		flush_i    = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 100) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d instructions never retired", exp_q.size());
			errors++;
			timed_out = 1'b1;
		end
		@(posedge clk); // last register write lands
	endtask

	task automatic sweep_regs();
		for (int r = 0; r < 32; r++) begin
			@(posedge clk);
			#1 dbg_raddr_i = 5'(r);
			@(negedge clk);
			compare_value($sformatf("dbg_rdata_o[x%0d]", r), dbg_rdata_o, want_rf[r]);
		end
	endtask

	// a held edge leaves both stage registers where they are
	always @(posedge clk) begin
		if (!hold_i)
			adv_cnt <= adv_cnt + 32'd1;
	end

	// retirement monitor
	always @(negedge clk) begin
		ret_t e;
		logic ebk;
		if (rst_n) begin
			ebk = 1'b0;
			if (hold_i && retire_valid_o) begin
				$display("retirement reported while hold is high");
				errors++;
			end
			if (retire_valid_o) begin
				if (exp_q.size() == 0) begin
					$display("retirement of x%0d with nothing outstanding", retire_rd_o);
					errors++;
				end else begin
					e = exp_q.pop_front();
					compare_value("retire_valid_o cycle", 64'(adv_cnt), 64'(e.due));
					compare_value("retire_rd_o", 64'(retire_rd_o), 64'(e.rd));
					compare_value("retire_data_o", retire_data_o, e.data);
					compare_value("retire_pc_o", retire_pc_o, e.pc);
					ebk = e.ebreak;
				end
			end
			compare_value("halt_o", 64'(halt_o), 64'(halt_seen | ebk));
			halt_seen = halt_seen | ebk;
		end
	end

	initial begin
		rst_n           = 1'b0;
		hold_i          = 1'b0;
		flush_i         = 1'b0;
		in_valid_i      = 1'b0;
		in_reg_wen_i    = 1'b0;
		in_reg_waddr_i  = '0;
		in_alu_res_i    = '0;
		in_store_data_i = '0;
		in_op_i         = '0;
		in_ebreak_i     = 1'b0;
		in_pc_i         = '0;
		dbg_raddr_i     = '0;
		timed_out       = 1'b0;
		build_table();
		repeat (16) @(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		compare_value("retire_valid_o", 64'(retire_valid_o), 64'd0);
		compare_value("halt_o", 64'(halt_o), 64'd0);
		compare_value("retire_pc_o", retire_pc_o, `RV_RESET_PC);
		apply_rows(0, n_dir);
		wait_drain();
		if (!timed_out) begin
			want_rf = mid_rf;
			sweep_regs();
			apply_rows(n_dir, tbl.size()); // random traffic issued every cycle
			wait_drain();
		end
		if (!timed_out) begin
			want_rf = mrf;
			sweep_regs();
		end
		$display("checks: %0d, errors: %0d", nchecks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
